// File: verilog/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Processor and bus address width
`define DC_ADDR_W       32

// Direct-mapped geometry, 128 lines of 16 words
`define DC_INDEX_W      7
`define DC_OFFSET_W     4
`define DC_TAG_W        19
`define DC_LINE_WORDS   16

// Posted uncached writes
`define DC_WFIFO_DEPTH  4

`endif

// File: verilog/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]        addr_t;
    typedef logic [31:0]                  word_t;
    typedef logic [`DC_TAG_W-1:0]         tag_t;
    typedef logic [`DC_INDEX_W-1:0]       index_t;
    typedef logic [`DC_OFFSET_W-1:0]      offset_t;
    typedef logic [3:0]                   byte_en_t;
    typedef logic [`DC_LINE_WORDS*32-1:0] line_t;    // Word 0 in the low bits

    typedef enum logic [2:0] {
        IDLE,
        FIFO_WAIT,
        CACHED_RSHAKE,
        CACHED_RWAIT,
        CACHED_WWAIT,
        CACHED_REFILL,
        UNCACHED_RSHAKE,
        UNCACHED_RETURN
    } rstate_t;

    typedef enum logic [2:0] {
        WIDLE            = 3'b000,
        UNCACHED_WSHAKE  = 3'b001,
        UNCACHED_WWRITE  = 3'b011,
        UNCACHED_WRESULT = 3'b010,
        CACHED_WSHAKE    = 3'b101,
        CACHED_WWRITE    = 3'b110,
        CACHED_WRESULT   = 3'b111
    } wstate_t;

endpackage

// File: verilog/dcache_store.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_store (
    input  logic                clk,
    input  logic                rst,
    input  dcache_pkg::index_t  index,
    input  logic                we,
    input  dcache_pkg::tag_t    wtag,
    input  dcache_pkg::line_t   wline,
    input  logic                set_dirty,
    output dcache_pkg::tag_t    rtag,
    output dcache_pkg::line_t   rline,
    output logic                valid,
    output logic                dirty
);

    localparam int LINES = 1 << `DC_INDEX_W;

    dcache_pkg::tag_t   tag_mem  [LINES];
    dcache_pkg::line_t  line_mem [LINES];
    logic [LINES-1:0]   valid_bits;
    logic [LINES-1:0]   dirty_bits;

    // Asynchronous read port
    assign rtag  = tag_mem[index];
    assign rline = line_mem[index];
    assign valid = valid_bits[index];
    assign dirty = dirty_bits[index];

    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[index]  <= wtag;
            line_mem[index] <= wline;
        end
    end

    // Refill clears dirty, write hit sets it
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (we) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= set_dirty;
        end
    end

    a_dirty_needs_we: assert property (@(posedge clk) disable iff (rst)
        set_dirty |-> we);

endmodule

// File: verilog/uncached_wfifo.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module uncached_wfifo (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  dcache_pkg::addr_t     push_addr,
    input  dcache_pkg::word_t     push_data,
    input  dcache_pkg::byte_en_t  push_be,
    input  logic                  pop,
    output dcache_pkg::addr_t     head_addr,
    output dcache_pkg::word_t     head_data,
    output dcache_pkg::byte_en_t  head_be,
    output logic                  full,
    output logic                  empty
);

    localparam int PTR_W = $clog2(`DC_WFIFO_DEPTH);
    localparam int CNT_W = $clog2(`DC_WFIFO_DEPTH + 1);

    dcache_pkg::addr_t     addr_q [`DC_WFIFO_DEPTH];
    dcache_pkg::word_t     data_q [`DC_WFIFO_DEPTH];
    dcache_pkg::byte_en_t  be_q   [`DC_WFIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;

    assign head_addr = addr_q[rd_ptr];
    assign head_data = data_q[rd_ptr];
    assign head_be   = be_q[rd_ptr];
    assign full      = count == CNT_W'(`DC_WFIFO_DEPTH);
    assign empty     = count == '0;

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr] <= push_addr;
            data_q[wr_ptr] <= push_data;
            be_q[wr_ptr]   <= push_be;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push);   // Depth is a power of two
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count  <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

// File: verilog/dcache_read_ctrl.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_read_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  den,
    input  logic                  addr_uncached,
    input  dcache_pkg::addr_t     addr,
    input  dcache_pkg::word_t     wdata,
    input  dcache_pkg::byte_en_t  byte_en,
    output logic                  data_ok,
    output dcache_pkg::word_t     data_rdata,
    output logic                  rd_req,
    output logic                  rd_uncached,
    output dcache_pkg::addr_t     rd_addr,
    input  logic                  rd_req_ok,
    input  logic                  rd_valid,
    input  dcache_pkg::word_t     rd_data,
    input  logic                  rd_last,
    input  dcache_pkg::tag_t      store_rtag,
    input  dcache_pkg::line_t     store_rline,
    input  logic                  store_valid,
    input  logic                  store_dirty,
    output logic                  store_we,
    output dcache_pkg::line_t     store_wline,
    output logic                  store_set_dirty,
    input  logic                  fifo_full,
    output logic                  fifo_push,
    input  logic                  wr_drained,
    input  logic                  writeback_busy,
    output logic                  victim_wb
);

    dcache_pkg::rstate_t  state, next_state;
    dcache_pkg::tag_t     tag;
    dcache_pkg::index_t   index;
    dcache_pkg::offset_t  offset;
    dcache_pkg::offset_t  beat_cnt;
    dcache_pkg::addr_t    line_addr;
    dcache_pkg::word_t    wmask;
    dcache_pkg::line_t    rx_line;
    dcache_pkg::line_t    merged_line;
    logic                 hit;

    assign tag       = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign index     = addr[`DC_OFFSET_W+2 +: `DC_INDEX_W];
    assign offset    = addr[2 +: `DC_OFFSET_W];
    assign line_addr = {tag, index, {(`DC_OFFSET_W+2){1'b0}}};
    assign hit       = store_valid && (store_rtag == tag);
    assign wmask     = {{8{byte_en[3]}}, {8{byte_en[2]}}, {8{byte_en[1]}}, {8{byte_en[0]}}};

    always_comb begin
        merged_line = store_rline;
        merged_line[32*offset +: 32] = (store_rline[32*offset +: 32] & ~wmask) | (wdata & wmask);
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= dcache_pkg::IDLE;
        else
            state <= next_state;
    end

    // Refill beats land in order from the line base
    always_ff @(posedge clk) begin
        if (rst || state != dcache_pkg::CACHED_RWAIT)
            beat_cnt <= '0;
        else if (rd_valid)
            beat_cnt <= beat_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::CACHED_RWAIT && rd_valid)
            rx_line[32*beat_cnt +: 32] <= rd_data;
    end

    always_comb begin
        next_state      = state;
        data_ok         = 1'b0;
        data_rdata      = '0;
        rd_req          = 1'b0;
        rd_uncached     = 1'b0;
        rd_addr         = '0;
        store_we        = 1'b0;
        store_wline     = merged_line;
        store_set_dirty = 1'b0;
        fifo_push       = 1'b0;
        victim_wb       = 1'b0;

        case (state)
            dcache_pkg::IDLE: begin
                if (den && addr_uncached && byte_en != '0) begin
                    fifo_push = !fifo_full;   // Posted and acked at once
                    data_ok   = !fifo_full;
                end else if (den && addr_uncached) begin
                    if (wr_drained) begin
                        rd_req      = 1'b1;
                        rd_uncached = 1'b1;
                        rd_addr     = addr;
                        next_state  = rd_req_ok ? dcache_pkg::UNCACHED_RETURN
                                                : dcache_pkg::UNCACHED_RSHAKE;
                    end else begin
                        next_state = dcache_pkg::FIFO_WAIT;
                    end
                end else if (den && hit) begin
                    data_ok         = 1'b1;
                    data_rdata      = store_rline[32*offset +: 32];
                    store_we        = byte_en != '0;
                    store_set_dirty = byte_en != '0;
                end else if (den) begin
                    // Victim goes out only once the posted writes are gone
                    if (store_dirty && !wr_drained) begin
                        next_state = dcache_pkg::FIFO_WAIT;
                    end else begin
                        rd_req     = 1'b1;
                        rd_addr    = line_addr;
                        victim_wb  = store_dirty;
                        next_state = rd_req_ok ? dcache_pkg::CACHED_RWAIT
                                               : dcache_pkg::CACHED_RSHAKE;
                    end
                end
            end
            dcache_pkg::FIFO_WAIT: begin
                if (wr_drained)
                    next_state = dcache_pkg::IDLE;
            end
            dcache_pkg::CACHED_RSHAKE: begin
                rd_req  = 1'b1;
                rd_addr = line_addr;
                if (rd_req_ok)
                    next_state = dcache_pkg::CACHED_RWAIT;
            end
            dcache_pkg::CACHED_RWAIT: begin
                if (rd_valid && rd_last)
                    next_state = writeback_busy ? dcache_pkg::CACHED_WWAIT
                                                : dcache_pkg::CACHED_REFILL;
            end
            dcache_pkg::CACHED_WWAIT: begin
                if (!writeback_busy)
                    next_state = dcache_pkg::CACHED_REFILL;
            end
            dcache_pkg::CACHED_REFILL: begin
                store_we    = 1'b1;
                store_wline = rx_line;
                data_ok     = byte_en == '0;   // A write retries as a hit
                data_rdata  = rx_line[32*offset +: 32];
                next_state  = dcache_pkg::IDLE;
            end
            dcache_pkg::UNCACHED_RSHAKE: begin
                rd_req      = 1'b1;
                rd_uncached = 1'b1;
                rd_addr     = addr;
                if (rd_req_ok)
                    next_state = dcache_pkg::UNCACHED_RETURN;
            end
            dcache_pkg::UNCACHED_RETURN: begin
                data_ok    = rd_valid;   // Single beat
                data_rdata = rd_data;
                if (rd_valid)
                    next_state = dcache_pkg::IDLE;
            end
            default: next_state = dcache_pkg::IDLE;
        endcase
    end

    a_no_store_during_refill: assert property (@(posedge clk) disable iff (rst)
        state == dcache_pkg::CACHED_RWAIT |-> !store_we);

endmodule

// File: verilog/dcache_write_ctrl.sv
`timescale 1ns/1ps

module dcache_write_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  victim_wb,
    input  dcache_pkg::tag_t      victim_tag,
    input  dcache_pkg::index_t    victim_index,
    input  dcache_pkg::line_t     victim_line,
    input  logic                  fifo_empty,
    input  dcache_pkg::addr_t     fifo_addr,
    input  dcache_pkg::word_t     fifo_data,
    input  dcache_pkg::byte_en_t  fifo_be,
    output logic                  fifo_pop,
    output logic                  wr_req,
    output logic                  wr_uncached,
    output dcache_pkg::addr_t     wr_addr,
    output dcache_pkg::byte_en_t  wr_byte_en,
    output logic                  wr_valid,
    output dcache_pkg::word_t     wr_data,
    output logic                  wr_last,
    input  logic                  wr_req_ok,
    input  logic                  wr_ready,
    input  logic                  wr_resp,
    output logic                  writeback_busy,
    output logic                  wr_drained
);

    dcache_pkg::wstate_t  state, next_state;
    dcache_pkg::tag_t     vic_tag;
    dcache_pkg::index_t   vic_index;
    dcache_pkg::offset_t  beat_cnt;
    dcache_pkg::addr_t    vic_addr;
    logic                 vic_pending;
    logic                 vic_start;

    assign vic_addr  = {vic_tag, vic_index, 6'd0};
    assign vic_start = state == dcache_pkg::WIDLE && fifo_empty && vic_pending;

    assign writeback_busy = vic_pending || state == dcache_pkg::CACHED_WSHAKE
                         || state == dcache_pkg::CACHED_WWRITE
                         || state == dcache_pkg::CACHED_WRESULT;
    assign wr_drained = fifo_empty && state == dcache_pkg::WIDLE;

    always_ff @(posedge clk) begin
        if (rst)
            state <= dcache_pkg::WIDLE;
        else
            state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (rst)
            vic_pending <= 1'b0;
        else if (victim_wb)
            vic_pending <= 1'b1;
        else if (vic_start)
            vic_pending <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (victim_wb) begin
            vic_tag   <= victim_tag;
            vic_index <= victim_index;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state != dcache_pkg::CACHED_WWRITE)
            beat_cnt <= '0;
        else if (wr_ready)
            beat_cnt <= beat_cnt + 1'b1;
    end

    always_comb begin
        next_state  = state;
        wr_req      = 1'b0;
        wr_uncached = 1'b0;
        wr_addr     = '0;
        wr_byte_en  = '0;
        wr_valid    = 1'b0;
        wr_data     = '0;
        wr_last     = 1'b0;
        fifo_pop    = 1'b0;

        case (state)
            dcache_pkg::WIDLE: begin
                if (!fifo_empty) begin   // Posted writes first
                    wr_req      = 1'b1;
                    wr_uncached = 1'b1;
                    wr_addr     = fifo_addr;
                    wr_byte_en  = fifo_be;
                    next_state  = wr_req_ok ? dcache_pkg::UNCACHED_WWRITE
                                            : dcache_pkg::UNCACHED_WSHAKE;
                end else if (vic_pending) begin
                    wr_req     = 1'b1;
                    wr_addr    = vic_addr;
                    wr_byte_en = 4'hf;
                    next_state = wr_req_ok ? dcache_pkg::CACHED_WWRITE
                                           : dcache_pkg::CACHED_WSHAKE;
                end
            end
            dcache_pkg::UNCACHED_WSHAKE: begin
                wr_req      = 1'b1;
                wr_uncached = 1'b1;
                wr_addr     = fifo_addr;
                wr_byte_en  = fifo_be;
                if (wr_req_ok)
                    next_state = dcache_pkg::UNCACHED_WWRITE;
            end
            dcache_pkg::UNCACHED_WWRITE: begin
                wr_valid   = 1'b1;
                wr_data    = fifo_data;
                wr_byte_en = fifo_be;
                wr_last    = 1'b1;
                fifo_pop   = wr_ready;
                if (wr_ready)
                    next_state = dcache_pkg::UNCACHED_WRESULT;
            end
            dcache_pkg::CACHED_WSHAKE: begin
                wr_req     = 1'b1;
                wr_addr    = vic_addr;
                wr_byte_en = 4'hf;
                if (wr_req_ok)
                    next_state = dcache_pkg::CACHED_WWRITE;
            end
            dcache_pkg::CACHED_WWRITE: begin
                wr_valid   = 1'b1;
                wr_data    = victim_line[32*beat_cnt +: 32];   // Still intact in the store
                wr_byte_en = 4'hf;
                wr_last    = &beat_cnt;
                if (wr_ready && &beat_cnt)
                    next_state = dcache_pkg::CACHED_WRESULT;
            end
            dcache_pkg::UNCACHED_WRESULT, dcache_pkg::CACHED_WRESULT: begin
                if (wr_resp)
                    next_state = dcache_pkg::WIDLE;
            end
            default: next_state = dcache_pkg::WIDLE;
        endcase
    end

    a_valid_in_write: assert property (@(posedge clk) disable iff (rst)
        wr_valid |-> (state == dcache_pkg::UNCACHED_WWRITE
                      || state == dcache_pkg::CACHED_WWRITE));

endmodule

// File: verilog/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  den,
    input  logic                  addr_uncached,
    input  dcache_pkg::addr_t     addr,
    input  dcache_pkg::word_t     wdata,
    input  dcache_pkg::byte_en_t  byte_en,
    output logic                  data_ok,
    output dcache_pkg::word_t     data_rdata,
    output logic                  rd_req,
    output logic                  rd_uncached,
    output dcache_pkg::addr_t     rd_addr,
    input  logic                  rd_req_ok,
    input  logic                  rd_valid,
    input  dcache_pkg::word_t     rd_data,
    input  logic                  rd_last,
    output logic                  wr_req,
    output logic                  wr_uncached,
    output dcache_pkg::addr_t     wr_addr,
    output dcache_pkg::byte_en_t  wr_byte_en,
    output logic                  wr_valid,
    output dcache_pkg::word_t     wr_data,
    output logic                  wr_last,
    input  logic                  wr_req_ok,
    input  logic                  wr_ready,
    input  logic                  wr_resp
);

    dcache_pkg::tag_t      line_tag, store_rtag;
    dcache_pkg::index_t    line_index;
    dcache_pkg::line_t     store_rline, store_wline;
    logic                  store_valid, store_dirty, store_we, store_set_dirty;
    dcache_pkg::addr_t     fifo_addr;
    dcache_pkg::word_t     fifo_data;
    dcache_pkg::byte_en_t  fifo_be;
    logic                  fifo_push, fifo_pop, fifo_full, fifo_empty;
    logic                  victim_wb, writeback_busy, wr_drained;

    // Store is indexed by the held processor address
    assign line_tag   = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign line_index = addr[`DC_OFFSET_W+2 +: `DC_INDEX_W];

    dcache_store i_store (
        .clk(clk), .rst(rst), .index(line_index), .we(store_we), .wtag(line_tag),
        .wline(store_wline), .set_dirty(store_set_dirty), .rtag(store_rtag),
        .rline(store_rline), .valid(store_valid), .dirty(store_dirty)
    );

    uncached_wfifo i_wfifo (
        .clk(clk), .rst(rst), .push(fifo_push), .push_addr(addr), .push_data(wdata),
        .push_be(byte_en), .pop(fifo_pop), .head_addr(fifo_addr), .head_data(fifo_data),
        .head_be(fifo_be), .full(fifo_full), .empty(fifo_empty)
    );

    dcache_read_ctrl i_read_ctrl (
        .clk(clk), .rst(rst), .den(den), .addr_uncached(addr_uncached), .addr(addr),
        .wdata(wdata), .byte_en(byte_en), .data_ok(data_ok), .data_rdata(data_rdata),
        .rd_req(rd_req), .rd_uncached(rd_uncached), .rd_addr(rd_addr),
        .rd_req_ok(rd_req_ok), .rd_valid(rd_valid), .rd_data(rd_data), .rd_last(rd_last),
        .store_rtag(store_rtag), .store_rline(store_rline), .store_valid(store_valid),
        .store_dirty(store_dirty), .store_we(store_we), .store_wline(store_wline),
        .store_set_dirty(store_set_dirty), .fifo_full(fifo_full), .fifo_push(fifo_push),
        .wr_drained(wr_drained), .writeback_busy(writeback_busy), .victim_wb(victim_wb)
    );

    dcache_write_ctrl i_write_ctrl (
        .clk(clk), .rst(rst), .victim_wb(victim_wb), .victim_tag(store_rtag),
        .victim_index(line_index), .victim_line(store_rline), .fifo_empty(fifo_empty),
        .fifo_addr(fifo_addr), .fifo_data(fifo_data), .fifo_be(fifo_be),
        .fifo_pop(fifo_pop), .wr_req(wr_req), .wr_uncached(wr_uncached),
        .wr_addr(wr_addr), .wr_byte_en(wr_byte_en), .wr_valid(wr_valid),
        .wr_data(wr_data), .wr_last(wr_last), .wr_req_ok(wr_req_ok),
        .wr_ready(wr_ready), .wr_resp(wr_resp), .writeback_busy(writeback_busy),
        .wr_drained(wr_drained)
    );

endmodule

// File: tests/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker #(
    parameter int TIMEOUT_CYCLES = 200
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  den,
    input  dcache_pkg::addr_t     addr,
    input  dcache_pkg::byte_en_t  byte_en,
    input  logic                  data_ok,
    input  dcache_pkg::word_t     data_rdata,
    input  dcache_pkg::word_t     exp_rdata,
    output int                    reads_checked,
    output int                    data_errors,
    output int                    timeout_errors,
    output int                    protocol_errors
);

    int wait_cycles;

    // Inputs change just after the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst) begin
            reads_checked   = 0;
            data_errors     = 0;
            timeout_errors  = 0;
            protocol_errors = 0;
            wait_cycles     = 0;
        end else begin
            if (data_ok && !den) begin
                $display("data_ok pulsed at %0t with no access pending", $time);
                protocol_errors++;
            end
            if (den && data_ok && byte_en == '0) begin
                reads_checked++;
                if (data_rdata !== exp_rdata) begin
                    $display("Error at %0t: data_rdata for address %h expected %h, got %h",
                             $time, addr, exp_rdata, data_rdata);
                    data_errors++;
                end
            end
            if (den && !data_ok) begin
                wait_cycles++;
                if (wait_cycles == TIMEOUT_CYCLES) begin
                    $display("Access to address %h got no data_ok within %0d cycles",
                             addr, TIMEOUT_CYCLES);
                    timeout_errors++;
                end
            end else begin
                wait_cycles = 0;   // Access done or bus idle
            end
        end
    end

endmodule

// File: tests/tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tb_dcache;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int STALL_SLOTS    = 512;

    logic                  clk;
    logic                  rst;
    logic                  den;
    logic                  addr_uncached;
    dcache_pkg::addr_t     addr;
    dcache_pkg::word_t     wdata;
    dcache_pkg::byte_en_t  byte_en;
    logic                  data_ok;
    dcache_pkg::word_t     data_rdata;
    logic                  rd_req;
    logic                  rd_uncached;
    dcache_pkg::addr_t     rd_addr;
    logic                  rd_req_ok;
    logic                  rd_valid;
    dcache_pkg::word_t     rd_data;
    logic                  rd_last;
    logic                  wr_req;
    logic                  wr_uncached;
    dcache_pkg::addr_t     wr_addr;
    dcache_pkg::byte_en_t  wr_byte_en;
    logic                  wr_valid;
    dcache_pkg::word_t     wr_data;
    logic                  wr_last;
    logic                  wr_req_ok;
    logic                  wr_ready;
    logic                  wr_resp;

    dcache_pkg::word_t     exp_rdata;
    int                    reads_checked;
    int                    data_errors;
    int                    timeout_errors;
    int                    protocol_errors;
    int                    tb_errors;
    int                    accesses;
    logic                  aborted;

    // Bus memory keyed by word address
    dcache_pkg::word_t     mem [logic [29:0]];
    int                    stall_table [STALL_SLOTS];
    int                    stall_idx;

    dcache_top i_dut (
        .clk(clk), .rst(rst), .den(den), .addr_uncached(addr_uncached), .addr(addr),
        .wdata(wdata), .byte_en(byte_en), .data_ok(data_ok), .data_rdata(data_rdata),
        .rd_req(rd_req), .rd_uncached(rd_uncached), .rd_addr(rd_addr),
        .rd_req_ok(rd_req_ok), .rd_valid(rd_valid), .rd_data(rd_data), .rd_last(rd_last),
        .wr_req(wr_req), .wr_uncached(wr_uncached), .wr_addr(wr_addr),
        .wr_byte_en(wr_byte_en), .wr_valid(wr_valid), .wr_data(wr_data),
        .wr_last(wr_last), .wr_req_ok(wr_req_ok), .wr_ready(wr_ready), .wr_resp(wr_resp)
    );

    dcache_checker #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) i_checker (
        .clk(clk), .rst(rst), .den(den), .addr(addr), .byte_en(byte_en),
        .data_ok(data_ok), .data_rdata(data_rdata), .exp_rdata(exp_rdata),
        .reads_checked(reads_checked), .data_errors(data_errors),
        .timeout_errors(timeout_errors), .protocol_errors(protocol_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Untouched words read as word address ^ 32'h5a5a0000
    function automatic dcache_pkg::word_t mem_read(input dcache_pkg::addr_t a);
        if (mem.exists(a[31:2]))
            return mem[a[31:2]];
        return {2'b00, a[31:2]} ^ 32'h5a5a0000;
    endfunction

    function automatic void mem_write(input dcache_pkg::addr_t a, input dcache_pkg::word_t d,
                                      input dcache_pkg::byte_en_t be);
        dcache_pkg::word_t cur;
        int b;
        cur = mem_read(a);
        for (b = 0; b < 4; b++) begin
            if (be[b])
                cur[8*b +: 8] = d[8*b +: 8];
        end
        mem[a[31:2]] = cur;
    endfunction

    task automatic stall_cycles();
        int n;
        n = stall_table[stall_idx % STALL_SLOTS];
        stall_idx++;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_access(input logic unc, input dcache_pkg::addr_t a,
                              input dcache_pkg::word_t wd, input dcache_pkg::byte_en_t be,
                              input dcache_pkg::word_t expected, output logic ok);
        int waited;
        den           = 1'b1;
        addr_uncached = unc;
        addr          = a;
        wdata         = wd;
        byte_en       = be;
        exp_rdata     = expected;
        waited        = 0;
        @(negedge clk);
        while (!data_ok && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        ok = data_ok;
        @(posedge clk);
        #1;
        den = 1'b0;
    endtask

    // Read channel answers after a stall with 16 beats or one uncached beat
    initial begin : read_channel
        dcache_pkg::addr_t base;
        int beats;
        int i;
        rd_req_ok = 1'b0;
        rd_valid  = 1'b0;
        rd_data   = '0;
        rd_last   = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && rd_req) begin
                base  = rd_addr;
                beats = rd_uncached ? 1 : `DC_LINE_WORDS;
                @(posedge clk);
                #1;
                stall_cycles();
                rd_req_ok = 1'b1;
                @(posedge clk);
                #1;
                rd_req_ok = 1'b0;
                for (i = 0; i < beats; i++) begin
                    stall_cycles();
                    rd_valid = 1'b1;
                    rd_data  = mem_read(base + 32'(4 * i));
                    rd_last  = i == beats - 1;
                    @(posedge clk);
                    #1;
                    rd_valid = 1'b0;
                    rd_last  = 1'b0;
                end
            end
        end
    end

    initial begin : write_channel
        dcache_pkg::addr_t base;
        int beat;
        int guard;
        int exp_beats;
        logic unc;
        logic last_seen;
        wr_req_ok = 1'b0;
        wr_ready  = 1'b0;
        wr_resp   = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && wr_req) begin
                base      = wr_addr;
                unc       = wr_uncached;
                exp_beats = unc ? 1 : `DC_LINE_WORDS;
                @(posedge clk);
                #1;
                stall_cycles();
                wr_req_ok = 1'b1;
                @(posedge clk);
                #1;
                wr_req_ok = 1'b0;
                beat      = 0;
                guard     = 0;
                last_seen = 1'b0;
                while (!last_seen && guard < TIMEOUT_CYCLES) begin
                    stall_cycles();
                    wr_ready = 1'b1;
                    @(negedge clk);
                    if (wr_valid) begin   // Beat taken at the next edge
                        mem_write(base + 32'(4 * beat), wr_data, wr_byte_en);
                        beat++;
                        last_seen = wr_last;
                    end
                    guard++;
                    @(posedge clk);
                    #1;
                    wr_ready = 1'b0;
                end
                if (!last_seen) begin
                    $display("Write burst to %h never delivered its last beat", base);
                    tb_errors++;
                end else if (beat != exp_beats) begin
                    $display("Error at %0t: burst beats for wr_uncached %b expected %0d, got %0d",
                             $time, unc, exp_beats, beat);
                    tb_errors++;
                end
                stall_cycles();
                wr_resp = 1'b1;
                @(posedge clk);
                #1;
                wr_resp = 1'b0;
            end
        end
    end

    initial begin
        int fd;
        int got;
        int k;
        int unsigned seed_draw;
        string text;
        logic unc;
        logic ok;
        dcache_pkg::addr_t a;
        dcache_pkg::word_t wd;
        dcache_pkg::word_t exp_word;
        dcache_pkg::byte_en_t be;

        seed_draw = $urandom(32'hdf89f277);
        for (k = 0; k < STALL_SLOTS; k++)
            stall_table[k] = $urandom % 3;   // Bus stall cycles only
        stall_idx     = 0;
        rst           = 1'b1;
        den           = 1'b0;
        addr_uncached = 1'b0;
        addr          = '0;
        wdata         = '0;
        byte_en       = '0;
        exp_rdata     = '0;
        tb_errors     = 0;
        accesses      = 0;
        aborted       = 1'b0;

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen("tests/dcache_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/dcache_patterns.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd) && !aborted) begin
                got = $fgets(text, fd);
                if (got > 0 && text.getc(0) != "#"
                    && $sscanf(text, "%h %h %h %h %h", unc, a, wd, be, exp_word) == 5) begin
                    run_access(unc, a, wd, be, exp_word, ok);
                    accesses++;
                    if (!ok)
                        aborted = 1'b1;   // DUT is stuck so later accesses mean nothing
                end
            end
            $fclose(fd);
        end
        if (accesses == 0) begin
            $display("No accesses were read from the pattern file");
            tb_errors++;
        end

        repeat (4) @(posedge clk);
        $display("Counts: accesses %0d reads %0d data %0d timeout %0d protocol %0d tb %0d",
                 accesses, reads_checked, data_errors, timeout_errors, protocol_errors,
                 tb_errors);
        if (data_errors == 0 && timeout_errors == 0 && protocol_errors == 0
            && tb_errors == 0 && !aborted) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: tests/dcache_patterns.txt
# Columns: uncached addr wdata byte_en expected_rdata, all hex
# byte_en 0 is a read; expected_rdata is ignored for writes
0 00001040 00000000 0 5a5a0410
0 0000107c 00000000 0 5a5a041f
0 00001048 deadbeef 3 00000000
0 00001048 00000000 0 5a5abeef
0 00003048 00000000 0 5a5a0c12
0 00001048 00000000 0 5a5abeef
0 0000104c 00000000 0 5a5a0413
0 00005000 12345678 f 00000000
0 00005000 00000000 0 12345678
1 80000010 11110000 f 00000000
1 80000010 22220000 f 00000000
1 80000014 aaaaaaaa f 00000000
1 80000014 000000bb 1 00000000
1 80000010 33330000 f 00000000
1 80000010 00000000 0 33330000
1 80000014 00000000 0 aaaaaabb
0 00002200 00000000 0 5a5a0880
1 00002200 00000000 0 5a5a0880

// File: verilog.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_store.sv
verilog/uncached_wfifo.sv
verilog/dcache_read_ctrl.sv
verilog/dcache_write_ctrl.sv
verilog/dcache_top.sv
tests/dcache_checker.sv
tests/tb_dcache.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_dcache
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "FAIL"; exit 1; \
	elif ! grep -q "Everything OK" $(LOG); then echo "FAIL: run did not finish"; exit 1; \
	else echo "PASS"; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
